// File: logic/cpu_pkg.sv
package cpu_pkg;

    // data path and bus width
    localparam int word_width = 8;
    // 16-word program memory
    localparam int addr_width = 4;
    localparam int mem_depth  = 16;

    // instruction opcodes, high nibble of a memory word
    // unlisted codes run as no-ops
    typedef enum logic [3:0] {
        lda = 4'd0,
        add = 4'd1,
        sub = 4'd2,
        sta = 4'd3,
        ldi = 4'd4,
        jmp = 4'd5,
        jc  = 4'd6,
        jz  = 4'd7,
        out = 4'd14,
        hlt = 4'd15
    } opcode_t;

    // five fixed steps per instruction
    typedef enum logic [2:0] {
        t0,
        t1,
        t2,
        t3,
        t4
    } step_t;

    // one memory byte, seen as an instruction or as plain data
    typedef union packed {
        struct packed {
            opcode_t                opcode;
            logic [addr_width-1:0] operand;
        } instr;
        logic [word_width-1:0] data;
    } mem_word_u;

endpackage

// File: logic/cpu_ctrl_if.sv
`timescale 1ns/1ps

interface cpu_ctrl_if import cpu_pkg::*; ();

    // program counter
    logic pc_inc;
    logic pc_out;
    logic pc_load;
    // memory address register and memory
    logic mar_load;
    logic mem_out;
    logic mem_write;
    // instruction register
    logic ir_load;
    logic ir_operand_out;
    // accumulator and alu
    logic a_load;
    logic a_out;
    logic alu_sub;
    logic alu_out;
    // b and output registers
    logic b_load;
    logic out_load;

    // status back to the sequencer
    opcode_t opcode;
    logic    carry;
    logic    zero;

    modport control (
        output pc_inc, pc_out, pc_load, mar_load, mem_out, mem_write,
        output ir_load, ir_operand_out, a_load, a_out, alu_sub, alu_out,
        output b_load, out_load,
        input  opcode, carry, zero
    );

    // mem_write goes straight to memory, not through the datapath
    modport dp (
        input  pc_inc, pc_out, pc_load, mar_load, mem_out,
        input  ir_load, ir_operand_out, a_load, a_out, alu_sub, alu_out,
        input  b_load, out_load,
        output opcode, carry, zero
    );

endinterface

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit import cpu_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic run,
    output logic halted,
    output logic out_valid,
    cpu_ctrl_if.control ctrl
);

    step_t step;
    logic  active;
    logic  halt_now;
    logic  jump_taken;

    // sequencer only moves while running and not halted
    assign active   = run && !halted;
    assign halt_now = active && (step == t2) && (ctrl.opcode == hlt);

    // conditional jumps use the stored flags
    assign jump_taken = (ctrl.opcode == jmp) ||
                        ((ctrl.opcode == jc) && ctrl.carry) ||
                        ((ctrl.opcode == jz) && ctrl.zero);

    always_ff @(posedge clk) begin
        if (reset) begin
            step      <= t0;
            halted    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            // output reg loads at end of t2, so flag it during t3
            out_valid <= active && (step == t2) && (ctrl.opcode == out);
            if (halt_now) begin
                // step counter stays frozen at t2
                halted <= 1'b1;
            end else if (active) begin
                step <= (step == t4) ? t0 : step_t'(step + 3'd1);
            end
        end
    end

    // control word per step
    always_comb begin
        ctrl.pc_inc         = 1'b0;
        ctrl.pc_out         = 1'b0;
        ctrl.pc_load        = 1'b0;
        ctrl.mar_load       = 1'b0;
        ctrl.mem_out        = 1'b0;
        ctrl.mem_write      = 1'b0;
        ctrl.ir_load        = 1'b0;
        ctrl.ir_operand_out = 1'b0;
        ctrl.a_load         = 1'b0;
        ctrl.a_out          = 1'b0;
        ctrl.alu_sub        = 1'b0;
        ctrl.alu_out        = 1'b0;
        ctrl.b_load         = 1'b0;
        ctrl.out_load       = 1'b0;
        if (active) begin
            case (step)
                // fetch address
                t0: begin
                    ctrl.pc_out   = 1'b1;
                    ctrl.mar_load = 1'b1;
                end
                // fetch instruction, bump pc
                t1: begin
                    ctrl.mem_out = 1'b1;
                    ctrl.ir_load = 1'b1;
                    ctrl.pc_inc  = 1'b1;
                end
                t2: begin
                    case (ctrl.opcode)
                        // operand address into mar
                        lda, add, sub, sta: begin
                            ctrl.ir_operand_out = 1'b1;
                            ctrl.mar_load       = 1'b1;
                        end
                        // immediate nibble into a
                        ldi: begin
                            ctrl.ir_operand_out = 1'b1;
                            ctrl.a_load         = 1'b1;
                        end
                        jmp, jc, jz: begin
                            ctrl.ir_operand_out = jump_taken;
                            ctrl.pc_load        = jump_taken;
                        end
                        out: begin
                            ctrl.a_out    = 1'b1;
                            ctrl.out_load = 1'b1;
                        end
                        default: ;
                    endcase
                end
                t3: begin
                    case (ctrl.opcode)
                        lda: begin
                            ctrl.mem_out = 1'b1;
                            ctrl.a_load  = 1'b1;
                        end
                        // second operand into b
                        add, sub: begin
                            ctrl.mem_out = 1'b1;
                            ctrl.b_load  = 1'b1;
                        end
                        // accumulator goes out on mem_wdata
                        sta: ctrl.mem_write = 1'b1;
                        default: ;
                    endcase
                end
                t4: begin
                    // alu result back into a, flags latch here
                    if ((ctrl.opcode == add) || (ctrl.opcode == sub)) begin
                        ctrl.alu_out = 1'b1;
                        ctrl.a_load  = 1'b1;
                        ctrl.alu_sub = (ctrl.opcode == sub);
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// File: logic/program_memory.sv
`timescale 1ns/1ps

module program_memory import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  run,
    input  logic [addr_width-1:0] mem_addr,
    input  logic [word_width-1:0] mem_wdata,
    input  logic                  mem_write,
    input  logic                  load_req,
    input  logic [addr_width-1:0] load_addr,
    input  logic [word_width-1:0] load_data,
    output logic [word_width-1:0] mem_rdata,
    output logic                  load_ack
);

    logic [word_width-1:0] mem [mem_depth];
    logic                  load_fire;

    // cpu read is combinational
    assign mem_rdata = mem[mem_addr];

    // new request, not yet acked, loader only while stopped
    assign load_fire = load_req && !load_ack && !run;

    // STA write port, loader writes share the same array
    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[mem_addr] <= mem_wdata;
        end else if (load_fire) begin
            mem[load_addr] <= load_data;
        end
    end

    // four-phase ack, the ack flop is the whole loader state
    always_ff @(posedge clk) begin
        if (reset) begin
            load_ack <= 1'b0;
        end else if (run) begin
            // never ack while the cpu runs
            load_ack <= 1'b0;
        end else if (load_fire) begin
            load_ack <= 1'b1;
        end else if (!load_req) begin
            // host dropped req, release ack
            load_ack <= 1'b0;
        end
    end

endmodule

// File: logic/datapath.sv
`timescale 1ns/1ps

module datapath import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [word_width-1:0] mem_rdata,
    output logic [addr_width-1:0] mem_addr,
    output logic [word_width-1:0] mem_wdata,
    output logic [word_width-1:0] out_value,
    output logic                  carry,
    output logic                  zero,
    cpu_ctrl_if.dp ctrl
);

    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] mar;
    mem_word_u             ir;
    mem_word_u             bus;
    logic [word_width-1:0] a_reg;
    logic [word_width-1:0] b_reg;
    logic [word_width-1:0] out_reg;
    logic [word_width-1:0] b_operand;
    logic [word_width:0]   alu_sum;

    // alu, subtract as a + ~b + 1
    assign b_operand = ctrl.alu_sub ? ~b_reg : b_reg;
    assign alu_sum   = {1'b0, a_reg} + {1'b0, b_operand} + {{word_width{1'b0}}, ctrl.alu_sub};

    // one-hot bus mux in place of the tri-state bus
    // nibble sources are zero extended
    always_comb begin
        bus.data = ({word_width{ctrl.pc_out}} &
                    {{(word_width-addr_width){1'b0}}, pc})
                 | ({word_width{ctrl.mem_out}} & mem_rdata)
                 | ({word_width{ctrl.ir_operand_out}} &
                    {{(word_width-addr_width){1'b0}}, ir.instr.operand})
                 | ({word_width{ctrl.a_out}} & a_reg)
                 | ({word_width{ctrl.alu_out}} & alu_sum[word_width-1:0]);
    end

    // pc, jump load wins over increment
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            pc <= bus.instr.operand;
        end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    // mar and ir
    always_ff @(posedge clk) begin
        if (reset) begin
            mar     <= '0;
            ir.data <= '0;
        end else begin
            if (ctrl.mar_load) begin
                mar <= bus.instr.operand;
            end
            if (ctrl.ir_load) begin
                ir <= bus;
            end
        end
    end

    // accumulator, b and output registers take the raw byte
    always_ff @(posedge clk) begin
        if (reset) begin
            a_reg   <= '0;
            b_reg   <= '0;
            out_reg <= '0;
        end else begin
            if (ctrl.a_load) begin
                a_reg <= bus.data;
            end
            if (ctrl.b_load) begin
                b_reg <= bus.data;
            end
            if (ctrl.out_load) begin
                out_reg <= bus.data;
            end
        end
    end

    // flags only move when the alu drives the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (ctrl.alu_out) begin
            carry <= alu_sum[word_width];
            zero  <= (alu_sum[word_width-1:0] == '0);
        end
    end

    assign mem_addr  = mar;
    // STA stores the accumulator
    assign mem_wdata = a_reg;
    assign out_value = out_reg;

    // status back to control unit
    assign ctrl.opcode = ir.instr.opcode;
    assign ctrl.carry  = carry;
    assign ctrl.zero   = zero;

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  run,
    input  logic                  load_req,
    input  logic [addr_width-1:0] load_addr,
    input  logic [word_width-1:0] load_data,
    output logic                  load_ack,
    output logic [word_width-1:0] out_value,
    output logic                  out_valid,
    output logic                  halted,
    output logic                  carry,
    output logic                  zero
);

    // memory side of the datapath
    logic [addr_width-1:0] mem_addr;
    logic [word_width-1:0] mem_wdata;
    logic [word_width-1:0] mem_rdata;

    // control word and status between sequencer and datapath
    cpu_ctrl_if ctrl_bus ();

    control_unit u_control (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .halted    (halted),
        .out_valid (out_valid),
        .ctrl      (ctrl_bus.control)
    );

    datapath u_datapath (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .out_value (out_value),
        .carry     (carry),
        .zero      (zero),
        .ctrl      (ctrl_bus.dp)
    );

    // STA write strobe taken directly from the control word
    program_memory u_memory (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_write (ctrl_bus.mem_write),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_data (load_data),
        .mem_rdata (mem_rdata),
        .load_ack  (load_ack)
    );

endmodule

// File: verif/cpu_monitor.sv
`timescale 1ns/1ps

module cpu_monitor import cpu_pkg::*; (
    input logic                  clk,
    input logic [word_width-1:0] out_value,
    input logic                  out_valid,
    input logic                  halted,
    input logic                  carry,
    input logic                  zero
);

    // expected outputs of the running program in order
    logic [word_width-1:0] expected_q[$];
    logic [word_width-1:0] want;
    int                    program_id     = 0;
    int                    mismatch_count = 0;
    int                    missing_count  = 0;
    int                    extra_count    = 0;
    int                    other_count    = 0;

    // registered outputs sampled mid cycle
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("program %0d: extra output 0x%02h beyond the expected sequence",
                         program_id, out_value);
                extra_count++;
            end else begin
                want = expected_q.pop_front();
                if (out_value !== want) begin
                    $display("Mismatch out_value: expected 0x%02h, got 0x%02h (program %0d)",
                             want, out_value, program_id);
                    mismatch_count++;
                end
            end
        end
    end

    task clear_expected(input int prog);
        program_id = prog;
        expected_q.delete();
    endtask

    task add_expected(input logic [word_width-1:0] value);
        expected_q.push_back(value);
    endtask

    // status outputs and flags must be low right after reset
    task check_idle();
        if (out_valid !== 1'b0) begin
            $display("Mismatch out_valid after reset: expected 0x0, got 0x%0h", out_valid);
            mismatch_count++;
        end
        if (halted !== 1'b0) begin
            $display("Mismatch halted after reset: expected 0x0, got 0x%0h", halted);
            mismatch_count++;
        end
        if (carry !== 1'b0) begin
            $display("Mismatch carry after reset: expected 0x0, got 0x%0h", carry);
            mismatch_count++;
        end
        if (zero !== 1'b0) begin
            $display("Mismatch zero after reset: expected 0x0, got 0x%0h", zero);
            mismatch_count++;
        end
    endtask

    task check_halt_held();
        if (halted !== 1'b1) begin
            report_failure("halted fell again before the next reset");
        end
    endtask

    // leftovers never appeared on out_valid
    task check_complete();
        while (expected_q.size() > 0) begin
            $display("program %0d: expected output 0x%02h never appeared",
                     program_id, expected_q[0]);
            missing_count++;
            expected_q.delete(0);
        end
    endtask

    task report_failure(input string msg);
        $display("program %0d: %s", program_id, msg);
        other_count++;
    endtask

endmodule

// File: verif/cpu_chk.sv
`timescale 1ns/1ps

module cpu_chk (
    input logic clk,
    input logic reset,
    input logic run,
    input logic load_req,
    input logic load_ack,
    input logic out_valid,
    input logic halted
);

    // ack answers a request seen on the previous edge
    ack_follows_req: assert property (@(posedge clk) disable iff (reset)
        $rose(load_ack) |-> $past(load_req))
        else $error("load_ack rose without load_req");

    // single cycle output strobe
    valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
        out_valid |=> !out_valid)
        else $error("out_valid high for two cycles in a row");

    valid_not_halted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !out_valid)
        else $error("out_valid high while halted");

    // loader is locked out while the cpu runs
    no_ack_running: assert property (@(posedge clk) disable iff (reset)
        run |-> !load_ack)
        else $error("load_ack high while run is high");

endmodule

bind cpu_top cpu_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .load_req  (load_req),
    .load_ack  (load_ack),
    .out_valid (out_valid),
    .halted    (halted)
);

// File: verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    // cycles allowed for one handshake phase
    localparam int handshake_limit = 50;
    // cycles allowed for a program to reach hlt
    localparam int halt_limit = 1000;
    // quiet window watched after halt
    localparam int settle_cycles = 20;

    logic                  clk;
    logic                  reset;
    logic                  run;
    logic                  load_req;
    logic [addr_width-1:0] load_addr;
    logic [word_width-1:0] load_data;
    logic                  load_ack;
    logic [word_width-1:0] out_value;
    logic                  out_valid;
    logic                  halted;
    logic                  carry;
    logic                  zero;

    // one program gathered from the stim file
    logic [addr_width-1:0] addr_q[$];
    logic [word_width-1:0] data_q[$];
    logic [word_width-1:0] result_q[$];

    cpu_top u_cpu_top (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_data (load_data),
        .load_ack  (load_ack),
        .out_value (out_value),
        .out_valid (out_valid),
        .halted    (halted),
        .carry     (carry),
        .zero      (zero)
    );

    cpu_monitor u_monitor (
        .clk       (clk),
        .out_value (out_value),
        .out_valid (out_valid),
        .halted    (halted),
        .carry     (carry),
        .zero      (zero)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        reset    = 1'b1;
        run      = 1'b0;
        load_req = 1'b0;
        repeat (8) next_cycle();
        reset = 1'b0;
    endtask

    // one word through the four-phase port
    task automatic load_word(input logic [addr_width-1:0] addr,
                             input logic [word_width-1:0] data);
        int cycles;
        load_addr = addr;
        load_data = data;
        load_req  = 1'b1;
        cycles    = 0;
        while ((load_ack !== 1'b1) && (cycles < handshake_limit)) begin
            next_cycle();
            cycles++;
        end
        if (load_ack !== 1'b1) begin
            u_monitor.report_failure($sformatf("load_ack never rose for address 0x%0h", addr));
        end
        load_req = 1'b0;
        cycles   = 0;
        while ((load_ack !== 1'b0) && (cycles < handshake_limit)) begin
            next_cycle();
            cycles++;
        end
        if (load_ack !== 1'b0) begin
            u_monitor.report_failure($sformatf("load_ack stuck high for address 0x%0h", addr));
        end
    endtask

    // start at pc 0, wait for hlt, then watch a quiet window
    task automatic run_program();
        int cycles;
        foreach (result_q[i]) begin
            u_monitor.add_expected(result_q[i]);
        end
        run    = 1'b1;
        cycles = 0;
        while ((halted !== 1'b1) && (cycles < halt_limit)) begin
            next_cycle();
            cycles++;
        end
        if (halted !== 1'b1) begin
            u_monitor.report_failure("halted never rose, the program did not reach hlt");
        end else begin
            // loader stays locked while run is high
            load_req = 1'b1;
            // any out_valid here shows up as an extra output
            repeat (settle_cycles) next_cycle();
            if (load_ack !== 1'b0) begin
                u_monitor.report_failure("load_ack answered a request while run was high");
            end
            load_req = 1'b0;
            u_monitor.check_halt_held();
        end
        u_monitor.check_complete();
        run = 1'b0;
    endtask

    initial begin
        int                    fd;
        int                    fields;
        int                    prog_num;
        string                 line;
        logic [addr_width-1:0] p_addr;
        logic [word_width-1:0] p_data;
        reset     = 1'b1;
        run       = 1'b0;
        load_req  = 1'b0;
        load_addr = '0;
        load_data = '0;
        prog_num  = 0;
        fd = $fopen("verif/cpu_stim.txt", "r");
        if (fd == 0) begin
            u_monitor.report_failure("cannot open verif/cpu_stim.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // first character picks the record kind
                case (line.getc(0))
                    "P": begin
                        fields = $sscanf(line, "P %h %h", p_addr, p_data);
                        if (fields == 2) begin
                            addr_q.push_back(p_addr);
                            data_q.push_back(p_data);
                        end else begin
                            u_monitor.report_failure("malformed load line in the stim file");
                        end
                    end
                    "E": begin
                        fields = $sscanf(line, "E %h", p_data);
                        if (fields == 1) begin
                            result_q.push_back(p_data);
                        end else begin
                            u_monitor.report_failure("malformed expect line in the stim file");
                        end
                    end
                    "R": begin
                        prog_num++;
                        u_monitor.clear_expected(prog_num);
                        apply_reset();
                        u_monitor.check_idle();
                        foreach (addr_q[i]) begin
                            load_word(addr_q[i], data_q[i]);
                        end
                        run_program();
                        addr_q.delete();
                        data_q.delete();
                        result_q.delete();
                    end
                    default: ;
                endcase
            end
            $fclose(fd);
            if (prog_num == 0) begin
                u_monitor.report_failure("the stim file held no program");
            end
        end
        $display("errors: mismatch %0d, missing %0d, extra %0d, other %0d",
                 u_monitor.mismatch_count, u_monitor.missing_count,
                 u_monitor.extra_count, u_monitor.other_count);
        if ((u_monitor.mismatch_count + u_monitor.missing_count +
             u_monitor.extra_count + u_monitor.other_count) == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verif/cpu_stim.txt
# P addr data loads one memory word, E value is the next expected output, all hex
# R resets the cpu, loads the words listed above and runs it to hlt
# arithmetic with lda, add, sub and out
P 0 09
P 1 1A
P 2 E0
P 3 2B
P 4 E0
P 5 1C
P 6 E0
P 7 F0
P 9 25
P A 13
P B 50
P C F0
E 38
E E8
E D8
R
# sta then lda of the same word, ldi immediates
P 0 47
P 1 E0
P 2 1E
P 3 3F
P 4 40
P 5 E0
P 6 0F
P 7 E0
P 8 F0
P E 30
P F AA
E 07
E 00
E 37
R
# countdown loop with sub, jz and jmp
P 0 0E
P 1 E0
P 2 2F
P 3 75
P 4 51
P 5 E0
P 6 F0
P E 03
P F 01
E 03
E 02
E 01
E 00
R
# add overflow loop with jc
P 0 0F
P 1 1E
P 2 E0
P 3 65
P 4 51
P 5 49
P 6 E0
P 7 F0
P E 60
P F 50
E B0
E 10
E 09
R

// File: files.f
logic/cpu_pkg.sv
logic/cpu_ctrl_if.sv
logic/control_unit.sv
logic/program_memory.sv
logic/datapath.sv
logic/cpu_top.sv
verif/cpu_monitor.sv
verif/cpu_chk.sv
verif/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cpu testbench with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

log=sim.log

verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcpu_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$log"; then
    exit 1
fi
exit 0
